// File: include/priv_consts.svh
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// one-hot positions in pr_type
`define UOP_W               4
`define INS_CSR             0
`define INS_CACHE           1
`define INS_ERTN            2
`define INS_IDLE            3

// csr numbers, 14 bits
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ERA             14'h006
`define CSR_SAVE0           14'h030
`define CSR_SAVE1           14'h031
`define CSR_SAVE2           14'h032
`define CSR_SAVE3           14'h033

// cacop codes in ins[4:3]
`define CACOP_STORE_TAG     2'd0
`define CACOP_IDX_INV       2'd1
`define CACOP_HIT_INV       2'd2

// cache geometry
`define CACHE_SETS          16
`define LINE_OFS_W          4

`endif

// File: hw/priv_types_pkg.sv
`include "priv_consts.svh"

package priv_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [`UOP_W-1:0] uop_t;
    typedef logic [13:0] csr_num_t;

    // one instruction in flight at a time
    typedef enum logic [3:0]
    {
        PR_INIT,
        PR_CSR,
        PR_CACOP_I_CALL,
        PR_CACOP_I_WAIT,
        PR_CACOP_D_CALL,
        PR_CACOP_D_WAIT,
        PR_ERTN,
        PR_IDLE_WAIT,
        PR_IDLE
    } pr_state_t;

endpackage

// File: hw/cache_types_pkg.sv
`include "priv_consts.svh"

package cache_types_pkg;

    typedef logic [1:0] cacop_op_t;

    // addr = {tag, index, offset}
    typedef logic [$clog2(`CACHE_SETS)-1:0] cache_index_t;
    typedef logic [31-$clog2(`CACHE_SETS)-`LINE_OFS_W:0] cache_tag_t;

    typedef enum logic [1:0]
    {
        CM_IDLE,
        CM_READ,
        CM_WRITE
    } cm_state_t;

endpackage

// File: hw/csr_file.sv
`timescale 1ns/1ns
`include "priv_consts.svh"

module csr_file
    import priv_types_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  csr_num_t csr_addr,
    input  logic     csr_ren,
    input  logic     csr_wen,
    input  word_t    csr_wdata,
    input  logic     ertn_en,
    output word_t    csr_rdata,
    output word_t    crmd
);

    localparam word_t CRMD_MASK = 32'h0000_01ff;
    localparam word_t PRMD_MASK = 32'h0000_0007;
    localparam word_t FULL_MASK = 32'hffff_ffff;

    word_t crmd_q;
    word_t prmd_q;
    word_t era_q;
    word_t save_q [4];
    word_t rd_val;

    function automatic word_t merge(input word_t old_v, input word_t new_v, input word_t mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    always_comb
    begin
        case (csr_addr)
            `CSR_CRMD:  rd_val = crmd_q;
            `CSR_PRMD:  rd_val = prmd_q;
            `CSR_ERA:   rd_val = era_q;
            `CSR_SAVE0: rd_val = save_q[0];
            `CSR_SAVE1: rd_val = save_q[1];
            `CSR_SAVE2: rd_val = save_q[2];
            `CSR_SAVE3: rd_val = save_q[3];
            default:    rd_val = '0;   // unimplemented
        endcase
    end

    assign csr_rdata = csr_ren ? rd_val : '0;
    assign crmd      = crmd_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd_q <= 32'h0000_0008;   // plv 0, da
            prmd_q <= '0;
            era_q  <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end
        else if (ertn_en)
            crmd_q[2:0] <= prmd_q[2:0];   // {pie, pplv} -> {ie, plv}
        else if (csr_wen)
        begin
            case (csr_addr)
                `CSR_CRMD:  crmd_q    <= merge(crmd_q, csr_wdata, CRMD_MASK);
                `CSR_PRMD:  prmd_q    <= merge(prmd_q, csr_wdata, PRMD_MASK);
                `CSR_ERA:   era_q     <= merge(era_q, csr_wdata, FULL_MASK);
                `CSR_SAVE0: save_q[0] <= merge(save_q[0], csr_wdata, FULL_MASK);
                `CSR_SAVE1: save_q[1] <= merge(save_q[1], csr_wdata, FULL_MASK);
                `CSR_SAVE2: save_q[2] <= merge(save_q[2], csr_wdata, FULL_MASK);
                `CSR_SAVE3: save_q[3] <= merge(save_q[3], csr_wdata, FULL_MASK);
                default:    era_q     <= era_q;
            endcase
        end
    end

    a_wen_with_ren: assert property (@(posedge clk) disable iff (!rstn)
        csr_wen |-> csr_ren);

endmodule

// File: hw/cache_maint.sv
`timescale 1ns/1ns
`include "priv_consts.svh"

module cache_maint
    import cache_types_pkg::*;
#(
    parameter int SETS = `CACHE_SETS
)
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        en,
    input  cacop_op_t   op,
    input  logic [31:0] vaddr,
    output logic        ready,
    output logic        done,
    output logic        idle,
    input  logic        fill_en,
    input  logic [31:0] fill_addr,
    input  logic [31:0] lookup_addr,
    output logic        hit
);

    cm_state_t    state;
    cacop_op_t    op_q;
    cache_index_t idx_q;
    cache_tag_t   tag_q;
    logic         match_q;
    logic         fill_ok;
    logic [SETS-1:0] valid;
    cache_tag_t   tags [SETS];

    function automatic cache_index_t idx_of(input logic [31:0] addr);
        return addr[`LINE_OFS_W +: $bits(cache_index_t)];
    endfunction

    function automatic cache_tag_t tag_of(input logic [31:0] addr);
        return addr[31 -: $bits(cache_tag_t)];
    endfunction

    assign idle    = (state == CM_IDLE);
    assign ready   = idle && en;
    assign done    = (state == CM_WRITE);
    assign fill_ok = fill_en && idle;   // fills during an op are dropped
    assign hit     = valid[idx_of(lookup_addr)] && (tags[idx_of(lookup_addr)] == tag_of(lookup_addr));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= CM_IDLE;
        else
        begin
            case (state)
                CM_IDLE:  state <= en ? CM_READ : CM_IDLE;
                CM_READ:  state <= CM_WRITE;
                default:  state <= CM_IDLE;
            endcase
        end
    end

    // operation latched on accept
    always_ff @(posedge clk)
    begin
        if (ready)
        begin
            op_q  <= op;
            idx_q <= idx_of(vaddr);
            tag_q <= tag_of(vaddr);
        end
        if (state == CM_READ)
            match_q <= valid[idx_q] && (tags[idx_q] == tag_q);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            valid <= '0;
        else if (fill_ok)
            valid[idx_of(fill_addr)] <= 1'b1;
        else if (state == CM_WRITE)
        begin
            case (op_q)
                `CACOP_STORE_TAG, `CACOP_IDX_INV: valid[idx_q] <= 1'b0;
                `CACOP_HIT_INV: valid[idx_q] <= valid[idx_q] && !match_q;
                default:        valid[idx_q] <= valid[idx_q];   // reserved code
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_ok)
            tags[idx_of(fill_addr)] <= tag_of(fill_addr);
    end

    a_done_then_idle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> idle);

endmodule

// File: hw/priv_exec.sv
`timescale 1ns/1ns
`include "priv_consts.svh"

module priv_exec
    import priv_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      en,
    input  instr_t    ins,
    input  uop_t      pr_type,
    input  word_t     rj_data,
    input  word_t     rd_data,
    output logic      done,
    output word_t     rd_wdata,
    output csr_num_t  csr_addr,
    output word_t     csr_wdata,
    output logic      csr_wen,
    output logic      csr_ren,
    input  word_t     csr_rdata,
    output cacop_op_t cacop_op,
    output word_t     cacop_vaddr,
    output logic      cacop_i_en,
    output logic      cacop_d_en,
    input  logic      cacop_i_ready,
    input  logic      cacop_d_ready,
    input  logic      cacop_i_done,
    input  logic      cacop_d_done,
    output logic      ertn_en,
    input  logic      i_idle,
    input  logic      d_idle,
    output logic      block_cache,
    output logic      block_clock
);

    csr_num_t   csr_num;
    logic [4:0] rj;
    logic       is_xchg;
    logic       is_icache;
    logic       is_dcache;
    word_t      imm_ext;
    pr_state_t  state;
    pr_state_t  state_nxt;

    assign csr_num   = ins[23:10];
    assign rj        = ins[9:5];
    assign is_xchg   = |rj[4:1];       // rj >= 2
    assign is_icache = pr_type[`INS_CACHE] && (ins[2:0] == 3'd0);
    assign is_dcache = pr_type[`INS_CACHE] && (ins[2:0] == 3'd1);

    assign imm_ext     = {{20{ins[21]}}, ins[21:10]};
    assign cacop_vaddr = rj_data + imm_ext;
    assign cacop_op    = ins[4:3];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= PR_INIT;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            PR_INIT:
            begin
                if (en)
                begin
                    if (pr_type[`INS_CSR])
                        state_nxt = PR_CSR;
                    else if (is_icache)
                        state_nxt = PR_CACOP_I_CALL;
                    else if (is_dcache)
                        state_nxt = PR_CACOP_D_CALL;
                    else if (pr_type[`INS_IDLE])
                        state_nxt = PR_IDLE_WAIT;
                    else
                        state_nxt = PR_ERTN;   // ertn, bad cacop target, unknown
                end
            end
            PR_CACOP_I_CALL:
            begin
                if (cacop_i_ready)
                    state_nxt = PR_CACOP_I_WAIT;
            end
            PR_CACOP_I_WAIT:
            begin
                if (cacop_i_done)
                    state_nxt = PR_INIT;
            end
            PR_CACOP_D_CALL:
            begin
                if (cacop_d_ready)
                    state_nxt = PR_CACOP_D_WAIT;
            end
            PR_CACOP_D_WAIT:
            begin
                if (cacop_d_done)
                    state_nxt = PR_INIT;
            end
            PR_IDLE_WAIT:
            begin
                if (i_idle && d_idle)
                    state_nxt = PR_IDLE;
            end
            default:
                state_nxt = PR_INIT;   // csr, ertn, idle are single cycle
        endcase
    end

    always_comb
    begin
        csr_addr    = '0;
        csr_wdata   = '0;
        csr_wen     = 1'b0;
        csr_ren     = 1'b0;
        done        = 1'b0;
        ertn_en     = 1'b0;
        block_cache = 1'b0;
        block_clock = 1'b0;
        case (state)
            PR_INIT:
            begin
                if (en && pr_type[`INS_CSR])
                begin
                    csr_addr = csr_num;
                    csr_ren  = 1'b1;
                end
                else if (en && pr_type[`INS_IDLE])
                    block_cache = 1'b1;
            end
            PR_CSR:
            begin
                csr_addr  = csr_num;
                csr_ren   = 1'b1;
                csr_wen   = |rj;   // rj 0 is a plain read
                csr_wdata = is_xchg ? ((rd_data & rj_data) | (rd_wdata & ~rj_data)) : rd_data;
                done      = 1'b1;
            end
            PR_CACOP_I_WAIT:
                done = cacop_i_done;
            PR_CACOP_D_WAIT:
                done = cacop_d_done;
            PR_ERTN:
            begin
                ertn_en = pr_type[`INS_ERTN];
                done    = 1'b1;
            end
            PR_IDLE_WAIT:
                block_cache = 1'b1;
            PR_IDLE:
            begin
                block_cache = 1'b1;
                block_clock = 1'b1;
                done        = 1'b1;
            end
            default:
                done = 1'b0;
        endcase
    end

    // old csr value, returned to rd and used for the exchange mask
    always_ff @(posedge clk)
    begin
        if (state == PR_INIT && en && pr_type[`INS_CSR])
            rd_wdata <= csr_rdata;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            cacop_i_en <= 1'b0;
            cacop_d_en <= 1'b0;
        end
        else
        begin
            cacop_i_en <= (state == PR_CACOP_I_CALL) && !cacop_i_ready;
            cacop_d_en <= (state == PR_CACOP_D_CALL) && !cacop_d_ready;
        end
    end

    a_no_done_in_init: assert property (@(posedge clk) disable iff (!rstn)
        (state == PR_INIT) |-> !done);

    a_one_cache_at_a_time: assert property (@(posedge clk) disable iff (!rstn)
        !(cacop_i_en && cacop_d_en));

endmodule

// File: hw/priv_unit_top.sv
`timescale 1ns/1ns

module priv_unit_top
    import priv_types_pkg::*;
    import cache_types_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   en,
    input  instr_t ins,
    input  uop_t   pr_type,
    input  word_t  rj_data,
    input  word_t  rd_data,
    output logic   done,
    output word_t  rd_wdata,
    input  logic   ic_fill_en,
    input  word_t  ic_fill_addr,
    input  word_t  ic_lookup_addr,
    output logic   ic_hit,
    input  logic   dc_fill_en,
    input  word_t  dc_fill_addr,
    input  word_t  dc_lookup_addr,
    output logic   dc_hit,
    output word_t  crmd,
    output logic   block_cache,
    output logic   block_clock
);

    csr_num_t  csr_addr;
    word_t     csr_wdata;
    word_t     csr_rdata;
    logic      csr_wen;
    logic      csr_ren;
    logic      ertn_en;
    cacop_op_t cacop_op;
    word_t     cacop_vaddr;
    logic      cacop_i_en;
    logic      cacop_d_en;
    logic      cacop_i_ready;
    logic      cacop_d_ready;
    logic      cacop_i_done;
    logic      cacop_d_done;
    logic      i_idle;
    logic      d_idle;

    priv_exec priv_exec0
    (
        .clk(clk), .rstn(rstn), .en(en), .ins(ins), .pr_type(pr_type),
        .rj_data(rj_data), .rd_data(rd_data), .done(done), .rd_wdata(rd_wdata),
        .csr_addr(csr_addr), .csr_wdata(csr_wdata), .csr_wen(csr_wen),
        .csr_ren(csr_ren), .csr_rdata(csr_rdata),
        .cacop_op(cacop_op), .cacop_vaddr(cacop_vaddr),
        .cacop_i_en(cacop_i_en), .cacop_d_en(cacop_d_en),
        .cacop_i_ready(cacop_i_ready), .cacop_d_ready(cacop_d_ready),
        .cacop_i_done(cacop_i_done), .cacop_d_done(cacop_d_done),
        .ertn_en(ertn_en), .i_idle(i_idle), .d_idle(d_idle),
        .block_cache(block_cache), .block_clock(block_clock)
    );

    csr_file csr_file0
    (
        .clk(clk), .rstn(rstn), .csr_addr(csr_addr), .csr_ren(csr_ren),
        .csr_wen(csr_wen), .csr_wdata(csr_wdata), .ertn_en(ertn_en),
        .csr_rdata(csr_rdata), .crmd(crmd)
    );

    cache_maint icache_maint0
    (
        .clk(clk), .rstn(rstn), .en(cacop_i_en), .op(cacop_op), .vaddr(cacop_vaddr),
        .ready(cacop_i_ready), .done(cacop_i_done), .idle(i_idle),
        .fill_en(ic_fill_en), .fill_addr(ic_fill_addr),
        .lookup_addr(ic_lookup_addr), .hit(ic_hit)
    );

    cache_maint dcache_maint0
    (
        .clk(clk), .rstn(rstn), .en(cacop_d_en), .op(cacop_op), .vaddr(cacop_vaddr),
        .ready(cacop_d_ready), .done(cacop_d_done), .idle(d_idle),
        .fill_en(dc_fill_en), .fill_addr(dc_fill_addr),
        .lookup_addr(dc_lookup_addr), .hit(dc_hit)
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen
(
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;   // 4 ns period
    end

    initial
    begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// File: dv/priv_checker.sv
`timescale 1ns/1ns

module priv_checker
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        en,
    input  logic        done,
    input  logic [31:0] rd_wdata,
    input  logic [31:0] crmd,
    input  logic        ic_hit,
    input  logic        dc_hit,
    input  logic        block_cache,
    input  logic        block_clock,
    input  logic        exp_rd_chk,
    input  logic [31:0] exp_rd_wdata,
    input  logic [31:0] exp_crmd,
    input  logic        exp_ic_hit,
    input  logic        exp_dc_hit,
    input  logic        exp_idle,
    input  logic [1:0]  exp_lat   // 0 any, 1 exactly one, 2 at least four
);

    int   check_count = 0;
    int   error_count = 0;
    int   lat;
    logic in_flight;
    logic active;

    assign active = en || in_flight;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // sampled at posedge, mid-cycle for inputs driven on negedge
    always @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            in_flight <= 1'b0;
            lat       <= 0;
        end
        else
        begin
            compare("crmd", crmd, exp_crmd);
            compare("ic_hit", ic_hit, exp_ic_hit);
            compare("dc_hit", dc_hit, exp_dc_hit);
            compare("block_cache", block_cache, active && exp_idle);
            compare("block_clock", block_clock, done && exp_idle);
            if (done)
            begin
                check_count++;
                if (!in_flight)
                begin
                    error_count++;
                    $display("%0t: done pulsed with no instruction in flight", $time);
                end
                else if ((exp_lat == 2'd1 && lat != 1) || (exp_lat == 2'd2 && lat < 4))
                begin
                    error_count++;
                    $display("%0t: done came %0d cycles after en, latency rule %0d broken",
                             $time, lat, exp_lat);
                end
                if (exp_rd_chk)
                    compare("rd_wdata", rd_wdata, exp_rd_wdata);
                in_flight <= 1'b0;
            end
            else if (active)
            begin
                in_flight <= 1'b1;
                lat       <= in_flight ? lat + 1 : 1;
            end
        end
    end

endmodule

// File: dv/priv_tb.sv
`timescale 1ns/1ns
`include "priv_consts.svh"

module priv_tb;

    localparam logic [1:0] LAT_ANY  = 2'd0;
    localparam logic [1:0] LAT_ONE  = 2'd1;
    localparam logic [1:0] LAT_MIN4 = 2'd2;

    logic              clk;
    logic              rstn;
    logic              en;
    logic [31:0]       ins;
    logic [`UOP_W-1:0] pr_type;
    logic [31:0]       rj_data;
    logic [31:0]       rd_data;
    logic              done;
    logic [31:0]       rd_wdata;
    logic              ic_fill_en;
    logic              dc_fill_en;
    logic [31:0]       ic_fill_addr;
    logic [31:0]       dc_fill_addr;
    logic [31:0]       ic_lookup_addr;
    logic [31:0]       dc_lookup_addr;
    logic              ic_hit;
    logic              dc_hit;
    logic [31:0]       crmd;
    logic              block_cache;
    logic              block_clock;
    logic              exp_rd_chk;
    logic [31:0]       exp_rd_wdata;
    logic [31:0]       exp_crmd;
    logic              exp_ic_hit;
    logic              exp_dc_hit;
    logic              exp_idle;
    logic [1:0]        exp_lat;

    // reference model
    logic [13:0] csr_nums [7];
    logic [31:0] csr_masks [7];
    logic [31:0] m_csr [7];
    logic        m_valid [2][16];
    logic [23:0] m_tag [2][16];
    logic [31:0] ic_lines [$];
    logic [31:0] dc_lines [$];
    int          timeouts = 0;
    logic        stop_run = 1'b0;

    tb_clk_gen clk_gen0 (.*);
    priv_unit_top dut0 (.*);
    priv_checker chk0 (.*);

    function automatic logic [`UOP_W-1:0] uop_bit(input int pos);
        uop_bit      = '0;
        uop_bit[pos] = 1'b1;
    endfunction

    function automatic int csr_slot(input logic [13:0] num);
        for (int k = 0; k < 7; k++)
            if (csr_nums[k] == num)
                return k;
        return -1;   // unimplemented
    endfunction

    // index addr[7:4], tag addr[31:8]
    function automatic logic model_hit(input int c, input logic [31:0] addr);
        return m_valid[c][addr[7:4]] && (m_tag[c][addr[7:4]] == addr[31:8]);
    endfunction

    function automatic logic [31:0] pick_line(input int c);
        if (c == 0)
            return ic_lines[$urandom % ic_lines.size()];
        return dc_lines[$urandom % dc_lines.size()];
    endfunction

    task automatic model_reset();
        csr_nums  = '{`CSR_CRMD, `CSR_PRMD, `CSR_ERA, `CSR_SAVE0,
                      `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};
        csr_masks = '{32'h1ff, 32'h7, '1, '1, '1, '1, '1};
        for (int k = 0; k < 7; k++)
            m_csr[k] = '0;
        m_csr[0] = 32'h8;   // crmd resets to plv 0 with da set
        for (int s = 0; s < 16; s++)
        begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
    endtask

    task automatic refresh_expect();
        exp_crmd   = m_csr[0];
        exp_ic_hit = model_hit(0, ic_lookup_addr);
        exp_dc_hit = model_hit(1, dc_lookup_addr);
    endtask

    task automatic issue(input logic [31:0] i_ins, input logic [`UOP_W-1:0] i_type,
                         input logic [31:0] i_rj, input logic [31:0] i_rd,
                         input logic [31:0] old_val, input logic [1:0] lat);
        int cyc;
        cyc = 0;
        if (!stop_run)
        begin
            ins          = i_ins;
            pr_type      = i_type;
            rj_data      = i_rj;
            rd_data      = i_rd;
            exp_rd_chk   = i_type[`INS_CSR];
            exp_rd_wdata = old_val;
            exp_idle     = i_type[`INS_IDLE];
            exp_lat      = lat;
            en           = 1'b1;
            do
            begin
                @(negedge clk);
                cyc++;
            end
            while (!done && cyc < 50);
            if (!done)
            begin
                $display("%0t: no done from the DUT within 50 cycles of en", $time);
                timeouts++;
                stop_run = 1'b1;
            end
            en = 1'b0;
            @(negedge clk);   // cache engine back in idle
        end
    endtask

    task automatic csr_op(input logic [13:0] num, input logic [4:0] rj,
                          input logic [31:0] rjd, input logic [31:0] rdd);
        int          s;
        logic [31:0] old;
        logic [31:0] nv;
        logic [31:0] ins_w;
        s            = csr_slot(num);
        old          = (s < 0) ? 32'h0 : m_csr[s];
        ins_w        = $urandom;
        ins_w[23:10] = num;
        ins_w[9:5]   = rj;
        issue(ins_w, uop_bit(`INS_CSR), rjd, rdd, old, LAT_ONE);
        if (rj == 5'd0)
            nv = old;
        else if (rj == 5'd1)
            nv = rdd;
        else
            nv = (rdd & rjd) | (old & ~rjd);   // masked exchange
        if (s >= 0)
            m_csr[s] = (old & ~csr_masks[s]) | (nv & csr_masks[s]);
        refresh_expect();
    endtask

    task automatic fill_line(input int c, input logic [31:0] addr);
        if (!stop_run)
        begin
            ic_fill_en   = (c == 0);
            dc_fill_en   = (c == 1);
            ic_fill_addr = addr;
            dc_fill_addr = addr;
            @(negedge clk);
            ic_fill_en = 1'b0;
            dc_fill_en = 1'b0;
            m_valid[c][addr[7:4]] = 1'b1;
            m_tag[c][addr[7:4]]   = addr[31:8];
            if (c == 0)
                ic_lines.push_back(addr);
            else
                dc_lines.push_back(addr);
            refresh_expect();
        end
    endtask

    task automatic look(input logic [31:0] addr);
        ic_lookup_addr = addr;
        dc_lookup_addr = addr;
        refresh_expect();
        @(negedge clk);
    endtask

    task automatic cacop(input logic [2:0] target, input logic [1:0] op,
                         input logic [31:0] vaddr);
        logic [31:0] ins_w;
        logic [31:0] imm;
        ins_w      = $urandom;
        ins_w[4:3] = op;
        ins_w[2:0] = target;
        imm        = {{20{ins_w[21]}}, ins_w[21:10]};
        issue(ins_w, uop_bit(`INS_CACHE), vaddr - imm, $urandom, 32'h0,
              (target < 3'd2) ? LAT_MIN4 : LAT_ONE);
        if (target < 3'd2)
        begin
            if (op != `CACOP_HIT_INV || model_hit(target, vaddr))
                m_valid[target][vaddr[7:4]] = 1'b0;
        end
        refresh_expect();
    endtask

    initial
    begin
        int unsigned seed_val;
        int          cyc;
        int          c;
        logic [31:0] tgt;
        logic [31:0] va;
        logic [31:0] mis;
        en             = 1'b0;
        ins            = '0;
        pr_type        = '0;
        rj_data        = '0;
        rd_data        = '0;
        ic_fill_en     = 1'b0;
        dc_fill_en     = 1'b0;
        ic_fill_addr   = '0;
        dc_fill_addr   = '0;
        ic_lookup_addr = '0;
        dc_lookup_addr = '0;
        exp_rd_chk     = 1'b0;
        exp_rd_wdata   = '0;
        exp_idle       = 1'b0;
        exp_lat        = LAT_ANY;
        seed_val       = $urandom(87);
        model_reset();
        refresh_expect();
        cyc = 0;
        while (rstn !== 1'b1 && cyc < 20)
        begin
            @(negedge clk);
            cyc++;
        end
        if (rstn !== 1'b1)
        begin
            $display("reset never released");
            timeouts++;
            stop_run = 1'b1;
        end
        @(negedge clk);

        for (int t = 0; t < 80 && !stop_run; t++)
        begin
            if ($urandom % 4 == 0)
                csr_op($urandom, $urandom, $urandom, $urandom);   // mostly unimplemented
            else
                csr_op(csr_nums[$urandom % 7], $urandom % 4, $urandom, $urandom);
        end

        for (int t = 0; t < 12 && !stop_run; t++)
        begin
            csr_op(`CSR_PRMD, 5'd1, $urandom, $urandom);
            issue($urandom, uop_bit(`INS_ERTN), $urandom, $urandom, 32'h0, LAT_ONE);
            m_csr[0] = (m_csr[0] & ~32'h7) | (m_csr[1] & 32'h7);
            refresh_expect();
        end

        for (int t = 0; t < 24 && !stop_run; t++)
            fill_line(t % 2, $urandom);
        for (int t = 0; t < 20 && !stop_run; t++)
        begin
            c        = $urandom % 2;
            tgt      = pick_line(c);
            va       = tgt;
            va[3:0]  = $urandom;
            if (t % 3 == 0)
                va[31:8] = $urandom;   // index ops ignore the tag
            look(tgt);
            cacop(c, $urandom % 2, va);
            look(tgt);
        end

        for (int t = 0; t < 16 && !stop_run; t++)
            fill_line(t % 2, $urandom);
        for (int t = 0; t < 20 && !stop_run; t++)
        begin
            c       = $urandom % 2;
            tgt     = pick_line(c);
            va      = tgt;
            va[3:0] = $urandom;
            if (t % 2)
            begin
                mis = ($urandom % 255) + 1;
                va  = va ^ (mis << 8);
            end
            look(tgt);
            cacop(c, `CACOP_HIT_INV, va);
            look(tgt);
        end

        for (int t = 0; t < 4 && !stop_run; t++)
        begin
            issue($urandom, uop_bit(`INS_IDLE), $urandom, $urandom, 32'h0, LAT_ANY);
            csr_op(`CSR_SAVE0, 5'd0, $urandom, $urandom);
        end

        for (int t = 0; t < 8 && !stop_run; t++)
        begin
            tgt = pick_line(t % 2);
            look(tgt);
            cacop(3'd2 + ($urandom % 6), $urandom % 3, tgt);
            look(tgt);
        end

        for (int t = 0; t < ic_lines.size() && !stop_run; t++)
            look(ic_lines[t]);
        for (int t = 0; t < dc_lines.size() && !stop_run; t++)
            look(dc_lines[t]);

        $display("checks %0d, mismatches %0d, timeouts %0d",
                 chk0.check_count, chk0.error_count, timeouts);
        if (chk0.error_count == 0 && timeouts == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hw/priv_types_pkg.sv
hw/cache_types_pkg.sv
hw/csr_file.sv
hw/cache_maint.sv
hw/priv_exec.sv
hw/priv_unit_top.sv
dv/tb_clk_gen.sv
dv/priv_checker.sv
dv/priv_tb.sv
